/* hw/jpeg_out_pkg.sv */
package jpeg_out_pkg;

    // Upstream code word, right-aligned.
    localparam int CODE_W = 32;
    localparam int LEN_W = 6;  // 0 to 32.

    // Group between bit packer and byte packer.
    localparam int MID_W = 64;
    localparam int MID_BYTES_W = 4;  // 0 to 8.

    // Output word.
    localparam int OUT_W = 128;
    localparam int OUT_BYTES_W = 5;  // 1 to 16.

    // Running byte total of the stream.
    localparam int SIZE_W = 20;

    // A data byte of this value is followed by 0x00.
    // The same value pads the end of a scan.
    localparam logic [7:0] STUFF_BYTE = 8'hFF;

endpackage

/* hw/jpeg_stream_ctrl.sv */
`timescale 1ns/1ps

module jpeg_stream_ctrl #(
    parameter int FRAME_CNT_W = 16
) (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   out_hold,
    input  logic                   out_valid,
    input  logic                   out_tlast,
    input  logic                   tail_req,

    output logic                   run,
    output logic                   in_hold,
    output logic [FRAME_CNT_W-1:0] frame_count
);

    logic word_taken;
    logic tail_seen;

    // Whole pipeline advances only when the sink is not holding.
    assign run = ~out_hold;

    // The tail cycle of the bit packer needs the input side to wait.
    assign in_hold = out_hold | tail_req;

    assign word_taken = out_valid & ~out_hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_count <= '0;
        end else if (word_taken && out_tlast) begin
            frame_count <= frame_count + 1'b1;  // One per finished scan.
        end
    end

    // Value of tail_req on the last cycle the pipeline moved.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tail_seen <= 1'b0;
        end else if (run) begin
            tail_seen <= tail_req;
        end
    end

    // A tail cycle always drains the bit packer, so the next moving
    // cycle cannot ask for another one.
    a_tail_single: assert property (
        @(posedge clk) disable iff (!resetn)
        (run && tail_req) |-> !tail_seen
    ) else $error("tail_req held over two run cycles");

endmodule

/* hw/jpeg_bit_packer.sv */
`timescale 1ns/1ps

module jpeg_bit_packer (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                run,

    input  logic [jpeg_out_pkg::CODE_W-1:0]     code,
    input  logic [jpeg_out_pkg::LEN_W-1:0]      len,
    input  logic                                tlast,
    input  logic                                valid,

    output logic [jpeg_out_pkg::MID_W-1:0]      grp_data,
    output logic [jpeg_out_pkg::MID_BYTES_W-1:0] grp_bytes,
    output logic                                grp_tlast,
    output logic                                grp_valid,
    output logic                                tail_req
);

    localparam int CW = jpeg_out_pkg::CODE_W;
    localparam int MW = jpeg_out_pkg::MID_W;
    localparam int LW = jpeg_out_pkg::LEN_W;
    localparam int ACC_W = CW + MW;  // 96 bits.

    logic [ACC_W-1:0] acc;  // Pending bits, left-aligned.
    logic [6:0]       cnt;  // Number of pending bits.

    logic             accept;
    logic [CW-1:0]    code_al;
    logic [ACC_W-1:0] merged;
    logic [ACC_W-1:0] padded;
    logic [6:0]       next_cnt;
    logic [6:0]       end_round;
    logic [6:0]       tail_round;
    logic             two_groups;

    // No input during the tail cycle.
    assign accept = valid & run & ~tail_req;

    // Left-align the code, dropping anything above len.
    assign code_al = code << (LW'(CW) - len);

    assign merged   = acc | ({code_al, {MW{1'b0}}} >> cnt);
    assign next_cnt = cnt + {1'b0, len};

    // Ones below the last code bit give the byte padding.
    assign padded = merged | ({ACC_W{1'b1}} >> next_cnt);

    assign end_round  = next_cnt + 7'd7;
    assign tail_round = cnt + 7'd7;
    assign two_groups = next_cnt > 7'(MW);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc       <= '0;
            cnt       <= '0;
            tail_req  <= 1'b0;
            grp_valid <= 1'b0;
        end else if (run) begin
            if (tail_req) begin
                // Second group of the scan end goes out now.
                acc       <= '0;
                cnt       <= '0;
                tail_req  <= 1'b0;
                grp_valid <= 1'b1;
            end else if (accept && tlast) begin
                if (two_groups) begin
                    acc      <= padded << MW;
                    cnt      <= next_cnt - 7'(MW);
                    tail_req <= 1'b1;
                end else begin
                    acc <= '0;
                    cnt <= '0;
                end
                grp_valid <= 1'b1;
            end else if (accept && next_cnt >= 7'(MW)) begin
                acc       <= merged << MW;  // Eight bytes complete.
                cnt       <= next_cnt - 7'(MW);
                grp_valid <= 1'b1;
            end else if (accept) begin
                acc       <= merged;
                cnt       <= next_cnt;
                grp_valid <= 1'b0;
            end else begin
                grp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            if (tail_req) begin
                grp_data  <= acc[ACC_W-1 -: MW];
                grp_bytes <= tail_round[6:3];
                grp_tlast <= 1'b1;
            end else if (accept && tlast) begin
                grp_data  <= padded[ACC_W-1 -: MW];
                grp_bytes <= two_groups ? 4'd8 : end_round[6:3];
                grp_tlast <= ~two_groups;
            end else if (accept) begin
                grp_data  <= merged[ACC_W-1 -: MW];
                grp_bytes <= 4'd8;
                grp_tlast <= 1'b0;
            end
        end
    end

    a_len_range: assert property (
        @(posedge clk) disable iff (!resetn)
        accept |-> (len <= LW'(CW))
    ) else $error("code length above 32 accepted");

endmodule

/* hw/jpeg_byte_packer.sv */
`timescale 1ns/1ps

module jpeg_byte_packer (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 run,

    input  logic [jpeg_out_pkg::MID_W-1:0]       grp_data,
    input  logic [jpeg_out_pkg::MID_BYTES_W-1:0] grp_bytes,
    input  logic                                 grp_tlast,
    input  logic                                 grp_valid,

    output logic [jpeg_out_pkg::OUT_W-1:0]       out_data,
    output logic [jpeg_out_pkg::OUT_BYTES_W-1:0] out_bytes,
    output logic                                 out_tlast,
    output logic                                 out_valid,
    input  logic                                 out_hold,
    output logic [jpeg_out_pkg::SIZE_W-1:0]      size
);

    localparam int MW  = jpeg_out_pkg::MID_W;
    localparam int OW  = jpeg_out_pkg::OUT_W;
    localparam int OBW = jpeg_out_pkg::OUT_BYTES_W;
    localparam int MBW = jpeg_out_pkg::MID_BYTES_W;
    localparam int SW  = jpeg_out_pkg::SIZE_W;
    localparam int NB  = MW / 8;  // Bytes per group.

    logic [OW-1:0]  st_data  [0:NB];
    logic [OBW-1:0] st_bytes [0:NB];

    // Group sits in the upper half, lower half takes the inserted zeros.
    assign st_data[0]  = {grp_data, {MW{1'b0}}};
    assign st_bytes[0] = {1'b0, grp_bytes};

    // Work from the last byte upward so a byte's lane is still original
    // when its stage looks at it.
    for (genvar i = 0; i < NB; i++) begin : g_stuff
        localparam int LO = MW + 8 * i;
        logic hit;

        assign hit = (st_data[i][LO+7 -: 8] == jpeg_out_pkg::STUFF_BYTE)
                     && (grp_bytes > MBW'(NB - 1 - i));

        assign st_data[i+1] = hit ?
            {st_data[i][OW-1:LO], 8'h00, st_data[i][LO-1:8]} : st_data[i];
        assign st_bytes[i+1] = st_bytes[i] + {{(OBW-1){1'b0}}, hit};
    end

    logic [OW-1:0]  s_data;  // Stuffed group, inverted.
    logic [OBW-1:0] s_bytes;
    logic           s_tlast;
    logic           s_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            s_valid <= 1'b0;
        end else if (run) begin
            s_valid <= grp_valid;
        end
    end

    // Unused lanes end up zero here and read back as 0xFF at the output.
    always_ff @(posedge clk) begin
        if (run && grp_valid) begin
            s_data  <= ~(st_data[NB] | ({OW{1'b1}} >> {st_bytes[NB], 3'b000}));
            s_bytes <= st_bytes[NB];
            s_tlast <= grp_tlast;
        end
    end

    logic [OW-1:0]   acc;       // Partial word, inverted.
    logic [3:0]      byte_cnt;
    logic [1:0]      ext_cnt;   // Scan end spilled past 16 bytes.
    logic [OBW-1:0]  next_cnt;
    logic [2*OW-1:0] merged;
    logic [OW-1:0]   nxt_hi;
    logic [OW-1:0]   nxt_lo;
    logic            ext_fire;
    logic            fits;
    logic            full;
    logic            last;
    logic            overflow;
    logic            emit;

    assign next_cnt = {1'b0, byte_cnt} + s_bytes;
    assign merged   = {acc, {OW{1'b0}}} | ({s_data, {OW{1'b0}}} >> {byte_cnt, 3'b000});
    assign nxt_hi   = merged[2*OW-1:OW];
    assign nxt_lo   = merged[OW-1:0];

    assign ext_fire = ext_cnt == 2'd3;
    assign full     = next_cnt >= OBW'(16);
    assign fits     = next_cnt <= OBW'(16);
    assign last     = ext_fire | (s_valid & s_tlast & fits);
    assign overflow = s_valid & s_tlast & ~fits;
    assign emit     = ext_fire | (s_valid & (full | s_tlast));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc      <= '0;
            byte_cnt <= '0;
            ext_cnt  <= '0;
        end else if (run) begin
            if (overflow) begin
                ext_cnt <= 2'd1;
            end else if (ext_cnt != 2'd0) begin
                ext_cnt <= ext_cnt + 2'd1;  // Wraps to idle after firing.
            end

            if (last) begin
                acc      <= '0;
                byte_cnt <= '0;
            end else if (s_valid && full) begin
                acc      <= nxt_lo;
                byte_cnt <= next_cnt[3:0];  // Minus 16.
            end else if (s_valid) begin
                acc      <= nxt_hi;
                byte_cnt <= next_cnt[3:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (run) begin
            out_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (run && emit) begin
            out_tlast <= last;
            if (ext_fire) begin
                out_data  <= ~acc;
                out_bytes <= {1'b0, byte_cnt};
            end else begin
                out_data  <= ~nxt_hi;
                out_bytes <= (s_tlast && fits) ? next_cnt : OBW'(16);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            size <= '0;
        end else if (out_valid && !out_hold) begin
            size <= size + SW'(out_bytes);
        end
    end

    a_bytes_nonzero: assert property (
        @(posedge clk) disable iff (!resetn)
        out_valid |-> (out_bytes != '0)
    ) else $error("output word with zero bytes");

    // The spilled remainder owns the packing stage until it is sent.
    a_ext_clear: assert property (
        @(posedge clk) disable iff (!resetn)
        (run && ext_cnt != 2'd0) |-> !s_valid
    ) else $error("group arrived during scan end extension");

endmodule

/* hw/jpeg_out_top.sv */
`timescale 1ns/1ps

module jpeg_out_top #(
    parameter int FRAME_CNT_W = 16
) (
    input  logic                                 clk,
    input  logic                                 resetn,

    input  logic [jpeg_out_pkg::CODE_W-1:0]      code,
    input  logic [jpeg_out_pkg::LEN_W-1:0]       len,
    input  logic                                 tlast,
    input  logic                                 valid,
    output logic                                 in_hold,

    output logic [jpeg_out_pkg::OUT_W-1:0]       out_data,
    output logic [jpeg_out_pkg::OUT_BYTES_W-1:0] out_bytes,
    output logic                                 out_tlast,
    output logic                                 out_valid,
    input  logic                                 out_hold,
    output logic [jpeg_out_pkg::SIZE_W-1:0]      size,
    output logic [FRAME_CNT_W-1:0]               frame_count
);

    logic                                 run;
    logic                                 tail_req;
    logic [jpeg_out_pkg::MID_W-1:0]       grp_data;
    logic [jpeg_out_pkg::MID_BYTES_W-1:0] grp_bytes;
    logic                                 grp_tlast;
    logic                                 grp_valid;

    jpeg_stream_ctrl #(
        .FRAME_CNT_W (FRAME_CNT_W)
    ) u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .out_hold    (out_hold),
        .out_valid   (out_valid),
        .out_tlast   (out_tlast),
        .tail_req    (tail_req),
        .run         (run),
        .in_hold     (in_hold),
        .frame_count (frame_count)
    );

    jpeg_bit_packer u_bit (
        .clk       (clk),
        .resetn    (resetn),
        .run       (run),
        .code      (code),
        .len       (len),
        .tlast     (tlast),
        .valid     (valid),
        .grp_data  (grp_data),
        .grp_bytes (grp_bytes),
        .grp_tlast (grp_tlast),
        .grp_valid (grp_valid),
        .tail_req  (tail_req)
    );

    jpeg_byte_packer u_byte (
        .clk       (clk),
        .resetn    (resetn),
        .run       (run),
        .grp_data  (grp_data),
        .grp_bytes (grp_bytes),
        .grp_tlast (grp_tlast),
        .grp_valid (grp_valid),
        .out_data  (out_data),
        .out_bytes (out_bytes),
        .out_tlast (out_tlast),
        .out_valid (out_valid),
        .out_hold  (out_hold),
        .size      (size)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

/* bench/tb_jpeg_out.sv */
`timescale 1ns/1ps

module tb_jpeg_out;

    localparam int FRAME_CNT_W = 16;
    localparam int N_STIM = 34;
    localparam int WAIT_MAX = 200;
    localparam int OW = jpeg_out_pkg::OUT_W;

    // Entry layout is {tlast, len, code} with code right-aligned.
    localparam logic [38:0] STIM [0:N_STIM-1] = '{
        {1'b0, 6'd1,  32'h0000_0001},  // Mixed lengths ending mid-byte.
        {1'b0, 6'd7,  32'h0000_002A},
        {1'b0, 6'd16, 32'h0000_1234},
        {1'b0, 6'd32, 32'hDEAD_BEEF},
        {1'b1, 6'd7,  32'h0000_0015},
        {1'b0, 6'd32, 32'hFF00_FF12},  // Stuffing over two words and a 0xFF pad byte.
        {1'b0, 6'd16, 32'h0000_FFFF},
        {1'b0, 6'd16, 32'h0000_0102},
        {1'b0, 6'd32, 32'h89AB_CDEF},
        {1'b0, 6'd32, 32'h7F7F_7F7F},
        {1'b1, 6'd5,  32'h0000_001F},
        {1'b0, 6'd32, 32'hFFFF_FFFF},  // Last group spills past 16 bytes.
        {1'b0, 6'd32, 32'h00FF_00FF},
        {1'b0, 6'd32, 32'h1234_5678},
        {1'b1, 6'd24, 32'h009A_BCDE},
        {1'b0, 6'd32, 32'h0F0F_0F0F},  // Tail cycle.
        {1'b0, 6'd8,  32'h0000_00F0},
        {1'b1, 6'd32, 32'hFFFF_FFFF},
        {1'b0, 6'd32, 32'hFFFF_FFFF},  // Tail cycle and spill together.
        {1'b0, 6'd32, 32'h00FF_00FF},
        {1'b0, 6'd32, 32'hFFFF_FFFF},
        {1'b0, 6'd24, 32'h00FF_FF12},
        {1'b1, 6'd32, 32'hFFFF_FFFF},
        {1'b0, 6'd1,  32'h0000_0000},  // Byte aligned end on 0xFF.
        {1'b0, 6'd1,  32'h0000_0001},
        {1'b0, 6'd7,  32'h0000_007F},
        {1'b0, 6'd16, 32'h0000_00FF},
        {1'b1, 6'd7,  32'h0000_007F},
        {1'b0, 6'd32, 32'h0123_4567},  // Exactly 16 bytes.
        {1'b0, 6'd32, 32'h89AB_CDEF},
        {1'b0, 6'd32, 32'h7654_3210},
        {1'b1, 6'd32, 32'hFEDC_BA98},
        {1'b0, 6'd16, 32'h0000_A5C3},  // Short scan ending mid-byte.
        {1'b1, 6'd3,  32'h0000_0002}
    };

    logic                                 clk;
    logic                                 resetn;
    logic [jpeg_out_pkg::CODE_W-1:0]      code;
    logic [jpeg_out_pkg::LEN_W-1:0]       len;
    logic                                 tlast;
    logic                                 valid;
    logic                                 in_hold;
    logic [OW-1:0]                        out_data;
    logic [jpeg_out_pkg::OUT_BYTES_W-1:0] out_bytes;
    logic                                 out_tlast;
    logic                                 out_valid;
    logic                                 out_hold;
    logic [jpeg_out_pkg::SIZE_W-1:0]      size;
    logic [FRAME_CNT_W-1:0]               frame_count;

    logic [7:0] exp_bytes [$];  // Stuffed stream in order.
    int         exp_cnt [$];
    logic       exp_last [$];
    logic [7:0] frame_q [$];
    int         exp_total;
    int         exp_frames;
    int         frames_done;

    logic [15:0]                          hold_lfsr;
    logic                                 hold_en;
    logic                                 was_held;
    logic [OW-1:0]                        held_data;
    logic [jpeg_out_pkg::OUT_BYTES_W-1:0] held_bytes;
    logic                                 held_tlast;

    tb_clock u_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    jpeg_out_top #(
        .FRAME_CNT_W (FRAME_CNT_W)
    ) dut (
        .clk         (clk),
        .resetn      (resetn),
        .code        (code),
        .len         (len),
        .tlast       (tlast),
        .valid       (valid),
        .in_hold     (in_hold),
        .out_data    (out_data),
        .out_bytes   (out_bytes),
        .out_tlast   (out_tlast),
        .out_valid   (out_valid),
        .out_hold    (out_hold),
        .size        (size),
        .frame_count (frame_count)
    );

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1.
        end
        return n;
    endfunction

    task automatic add_stuffed_byte(input logic [7:0] v);
        frame_q.push_back(v);
        if (v == 8'hFF) begin
            frame_q.push_back(8'h00);
        end
    endtask

    // Expected stream straight from the table.
    task automatic build_model();
        logic [31:0] c;
        int          l;
        logic [7:0]  cur;
        int          nbits;
        int          left;
        cur = 8'h00;
        nbits = 0;
        exp_total = 0;
        exp_frames = 0;
        for (int i = 0; i < N_STIM; i++) begin
            c = STIM[i][31:0];
            l = int'(STIM[i][37:32]);
            for (int b = l - 1; b >= 0; b--) begin
                cur = {cur[6:0], c[b]};
                nbits++;
                if (nbits == 8) begin
                    add_stuffed_byte(cur);
                    nbits = 0;
                end
            end
            if (STIM[i][38]) begin
                if (nbits != 0) begin
                    cur = (cur << (8 - nbits)) | (8'hFF >> nbits);  // One-bit padding.
                    add_stuffed_byte(cur);
                    nbits = 0;
                end
                left = frame_q.size();
                exp_total += left;
                exp_frames++;
                while (left > 16) begin
                    exp_cnt.push_back(16);
                    exp_last.push_back(1'b0);
                    left -= 16;
                end
                exp_cnt.push_back(left);
                exp_last.push_back(1'b1);
                while (frame_q.size() > 0) begin
                    exp_bytes.push_back(frame_q.pop_front());
                end
            end
        end
    endtask

    task automatic send_entry(input int idx);
        int   waited;
        logic taken;
        code   = STIM[idx][31:0];
        len    = STIM[idx][37:32];
        tlast  = STIM[idx][38];
        valid  = 1'b1;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !in_hold;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited >= WAIT_MAX) begin
                $display("Table entry %0d was not accepted within %0d cycles.", idx, WAIT_MAX);
                fail_run();
            end
        end
    endtask

    task automatic wait_frame_done(input int n);
        int waited;
        waited = 0;
        while (frames_done != n) begin
            @(posedge clk);
            #1;
            waited++;
            if (frames_done != n && waited >= WAIT_MAX) begin
                $display("Frame %0d did not complete within %0d cycles.", n - 1, WAIT_MAX);
                fail_run();
            end
        end
        assert (int'(frame_count) == n) else begin
            $display("ERROR %0t frame_count expected %0d got %0d", $time, n, frame_count);
            fail_run();
        end
    endtask

    task automatic check_word();
        int         n;
        logic       last;
        logic [7:0] want;
        logic [7:0] got;
        assert (exp_cnt.size() > 0) else begin
            $display("An output word arrived at %0t after all expected words.", $time);
            fail_run();
        end
        n = exp_cnt.pop_front();
        last = exp_last.pop_front();
        assert (int'(out_bytes) == n) else begin
            $display("ERROR %0t out_bytes expected %0d got %0d", $time, n, out_bytes);
            fail_run();
        end
        assert (out_tlast === last) else begin
            $display("ERROR %0t out_tlast expected %0b got %0b", $time, last, out_tlast);
            fail_run();
        end
        for (int b = 0; b < n; b++) begin
            want = exp_bytes.pop_front();
            got = out_data[OW - 1 - 8 * b -: 8];  // First byte in the top lane.
            assert (got === want) else begin
                $display("ERROR %0t out_data byte %0d expected %02h got %02h",
                         $time, b, want, got);
                fail_run();
            end
        end
        if (last) begin
            frames_done++;
        end
    endtask

    // Random sink hold from one LFSR bit per cycle.
    always begin
        @(posedge clk);
        #1;
        if (hold_en) begin
            hold_lfsr = lfsr_next(hold_lfsr);
            out_hold = hold_lfsr[0];
        end else begin
            out_hold = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (resetn === 1'b1) begin
            if (was_held) begin
                assert (out_valid === 1'b1) else begin
                    $display("ERROR %0t out_valid expected 1 got %0b", $time, out_valid);
                    fail_run();
                end
                assert (out_bytes === held_bytes) else begin
                    $display("ERROR %0t out_bytes expected %0d got %0d",
                             $time, held_bytes, out_bytes);
                    fail_run();
                end
                assert (out_tlast === held_tlast) else begin
                    $display("ERROR %0t out_tlast expected %0b got %0b",
                             $time, held_tlast, out_tlast);
                    fail_run();
                end
                assert (out_data === held_data) else begin
                    $display("ERROR %0t out_data expected %032h got %032h",
                             $time, held_data, out_data);
                    fail_run();
                end
            end
            was_held   = out_valid & out_hold;
            held_data  = out_data;
            held_bytes = out_bytes;
            held_tlast = out_tlast;
            if (out_valid && !out_hold) begin
                check_word();
            end
        end
    end

    initial begin
        int waited;
        int frames_sent;
        code        = '0;
        len         = '0;
        tlast       = 1'b0;
        valid       = 1'b0;
        out_hold    = 1'b0;
        hold_en     = 1'b0;
        hold_lfsr   = 16'd18614;
        was_held    = 1'b0;
        frames_done = 0;
        frames_sent = 0;
        build_model();

        waited = 0;
        while (resetn !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited >= WAIT_MAX) begin
                $display("Reset was not released within %0d cycles.", WAIT_MAX);
                fail_run();
            end
        end

        @(negedge clk);
        assert (out_valid === 1'b0) else begin
            $display("ERROR %0t out_valid expected 0 got %0b", $time, out_valid);
            fail_run();
        end
        assert (in_hold === 1'b0) else begin
            $display("ERROR %0t in_hold expected 0 got %0b", $time, in_hold);
            fail_run();
        end
        assert (size === '0) else begin
            $display("ERROR %0t size expected 0 got %0d", $time, size);
            fail_run();
        end
        assert (frame_count === '0) else begin
            $display("ERROR %0t frame_count expected 0 got %0d", $time, frame_count);
            fail_run();
        end
        hold_en = 1'b1;
        @(posedge clk);
        #1;

        for (int i = 0; i < N_STIM; i++) begin
            send_entry(i);
            if (STIM[i][38]) begin
                valid = 1'b0;
                frames_sent++;
                wait_frame_done(frames_sent);  // Drain before the next scan.
            end
        end

        assert (exp_cnt.size() == 0) else begin
            $display("%0d expected output words never arrived.", exp_cnt.size());
            fail_run();
        end
        assert (int'(size) == exp_total) else begin
            $display("ERROR %0t size expected %0d got %0d", $time, exp_total, size);
            fail_run();
        end
        assert (int'(frame_count) == exp_frames) else begin
            $display("ERROR %0t frame_count expected %0d got %0d",
                     $time, exp_frames, frame_count);
            fail_run();
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* build.f */
hw/jpeg_out_pkg.sv
hw/jpeg_stream_ctrl.sv
hw/jpeg_bit_packer.sv
hw/jpeg_byte_packer.sv
hw/jpeg_out_top.sv
bench/tb_clock.sv
bench/tb_jpeg_out.sv

/* Makefile */
TOP := tb_jpeg_out
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "test did not complete"; exit 1; fi
	@echo "test ok"

clean:
	rm -rf obj_dir $(LOG)
